// File: rtl/burst_cmd_arbiter.sv
`timescale 1ns/1ps

module burst_cmd_arbiter
   (
    input  logic clk,
    input  logic arst_n,

    input  logic [burst_map_pkg::N_PORTS-1:0] piece_valid,
    input  burst_map_pkg::t_addr piece_addr_0,
    input  burst_map_pkg::t_addr piece_addr_1,
    input  burst_map_pkg::t_s_burstcount piece_burstcount_0,
    input  burst_map_pkg::t_s_burstcount piece_burstcount_1,
    output logic [burst_map_pkg::N_PORTS-1:0] piece_accept,

    output logic cmd_valid,
    output burst_map_pkg::t_port_id cmd_port,
    output burst_map_pkg::t_addr cmd_addr,
    output burst_map_pkg::t_s_burstcount cmd_burstcount,
    input  logic cmd_accept
    );

    import burst_map_pkg::*;

    // Port that won the most recent transfer
    t_port_id last_port;

    // Port after last_port in round-robin order
    t_port_id cand_port;
    t_port_id grant;
    logic xfer;

    assign cand_port = last_port + t_port_id'(1);

    // Prefer the other port, fall back to the last winner
    always_comb
    begin
        if (piece_valid[cand_port])
        begin
            grant = cand_port;
        end
        else
        begin
            grant = last_port;
        end
    end

    assign cmd_valid = piece_valid[grant];
    assign cmd_port = grant;
    assign cmd_addr = (grant == t_port_id'(1)) ? piece_addr_1 : piece_addr_0;
    assign cmd_burstcount = (grant == t_port_id'(1)) ? piece_burstcount_1 : piece_burstcount_0;

    // A transfer needs a valid piece and the slave's accept in one cycle
    assign xfer = cmd_valid && cmd_accept;

    // Only the granted gearbox sees the accept
    always_comb
    begin
        for (int i = 0; i < N_PORTS; i++)
        begin
            piece_accept[i] = xfer && (grant == t_port_id'(i));
        end
    end

    // Starting at port 1 hands the first grant to port 0
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            last_port <= t_port_id'(1);
        end
        else if (xfer)
        begin
            last_port <= grant;
        end
    end

    a_accept_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(piece_accept))
        else $error("burst_cmd_arbiter: accept to more than one port");

endmodule

// File: rtl/burst_cmd_fifo.sv
`timescale 1ns/1ps

module burst_cmd_fifo
  #(
    parameter int FIFO_DEPTH = 2
    )
   (
    input  logic clk,
    input  logic arst_n,

    input  logic push,
    input  burst_map_pkg::t_addr push_addr,
    input  burst_map_pkg::t_m_burstcount push_burstcount,

    input  logic pop,
    output logic empty,
    output logic full,
    output burst_map_pkg::t_addr head_addr,
    output burst_map_pkg::t_m_burstcount head_burstcount
    );

    import burst_map_pkg::*;

    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_WIDTH-1:0] t_ptr;
    typedef logic [CNT_WIDTH-1:0] t_cnt;

    // Command storage, one address and one count per entry
    t_addr mem_addr [FIFO_DEPTH];
    t_m_burstcount mem_burstcount [FIFO_DEPTH];

    t_ptr wr_ptr;
    t_ptr rd_ptr;
    t_cnt count;

    logic do_push;
    logic do_pop;

    // Pointers wrap at FIFO_DEPTH, which need not be a power of two
    function automatic t_ptr ptr_next(input t_ptr p);
        if (p == t_ptr'(FIFO_DEPTH - 1))
        begin
            return '0;
        end
        return p + t_ptr'(1);
    endfunction

    // An illegal push or pop leaves the queue untouched
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // Flags come straight from the occupancy count
    assign empty = (count == '0);
    assign full = (count == t_cnt'(FIFO_DEPTH));

    // The head entry is visible the cycle after it was written
    assign head_addr = mem_addr[rd_ptr];
    assign head_burstcount = mem_burstcount[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem_addr[wr_ptr] <= push_addr;
            mem_burstcount[wr_ptr] <= push_burstcount;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop)
            begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // A push and a pop together keep the count
            if (do_push && !do_pop)
            begin
                count <= count + t_cnt'(1);
            end
            else if (do_pop && !do_push)
            begin
                count <= count - t_cnt'(1);
            end
        end
    end

    // The requester must watch full before it strobes a new command
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        !(push && full))
        else $error("burst_cmd_fifo: push while full");

    // The gearbox only loads from a queue that holds a command
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        !(pop && empty))
        else $error("burst_cmd_fifo: pop while empty");

endmodule

// File: rtl/burst_map_pkg.sv
package burst_map_pkg;

    // Beat addresses count bus words and not bytes
    parameter int ADDR_WIDTH = 16;

    // Requester burst counts reach 64 beats in origin-0 form
    parameter int M_BURST_WIDTH = 6;

    // The slave accepts at most 8 beats per command
    parameter int S_BURST_WIDTH = 3;

    // Two requesters share one slave command bus
    parameter int N_PORTS = 2;

    // Address of the first beat of a command
    typedef logic [ADDR_WIDTH-1:0] t_addr;

    // Requester burst count, where 0 means one beat
    typedef logic [M_BURST_WIDTH-1:0] t_m_burstcount;

    // Slave burst count, also origin 0
    typedef logic [S_BURST_WIDTH-1:0] t_s_burstcount;

    // Index of a requester on the shared bus
    typedef logic [$clog2(N_PORTS)-1:0] t_port_id;

endpackage

// File: rtl/burst_split_top.sv
`timescale 1ns/1ps

module burst_split_top
  #(
    parameter int PAGE_SIZE = 16,
    parameter int FIFO_DEPTH = 2
    )
   (
    input  logic clk,
    input  logic arst_n,

    input  logic [burst_map_pkg::N_PORTS-1:0] req_valid,
    input  burst_map_pkg::t_addr req_addr_0,
    input  burst_map_pkg::t_addr req_addr_1,
    input  burst_map_pkg::t_m_burstcount req_burstcount_0,
    input  burst_map_pkg::t_m_burstcount req_burstcount_1,
    output logic [burst_map_pkg::N_PORTS-1:0] req_full,

    output logic cmd_valid,
    output burst_map_pkg::t_port_id cmd_port,
    output burst_map_pkg::t_addr cmd_addr,
    output burst_map_pkg::t_s_burstcount cmd_burstcount,
    input  logic cmd_accept
    );

    import burst_map_pkg::*;

    // Queue heads feeding each gearbox
    logic [N_PORTS-1:0] q_empty;
    logic [N_PORTS-1:0] q_load;
    t_addr head_addr_0;
    t_addr head_addr_1;
    t_m_burstcount head_burstcount_0;
    t_m_burstcount head_burstcount_1;

    // Pieces offered by each gearbox to the arbiter
    logic [N_PORTS-1:0] piece_valid;
    logic [N_PORTS-1:0] piece_accept;
    t_addr piece_addr_0;
    t_addr piece_addr_1;
    t_s_burstcount piece_burstcount_0;
    t_s_burstcount piece_burstcount_1;

    // Lane 0
    burst_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_0_inst
       (
        .clk, .arst_n,
        .push(req_valid[0]), .push_addr(req_addr_0), .push_burstcount(req_burstcount_0),
        .pop(q_load[0]), .empty(q_empty[0]), .full(req_full[0]),
        .head_addr(head_addr_0), .head_burstcount(head_burstcount_0)
        );

    burstcount0_gearbox #(.PAGE_SIZE(PAGE_SIZE)) gearbox_0_inst
       (
        .clk, .arst_n,
        .empty(q_empty[0]), .head_addr(head_addr_0), .head_burstcount(head_burstcount_0),
        .load(q_load[0]), .piece_accept(piece_accept[0]), .piece_valid(piece_valid[0]),
        .piece_addr(piece_addr_0), .piece_burstcount(piece_burstcount_0)
        );

    // Lane 1
    burst_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_1_inst
       (
        .clk, .arst_n,
        .push(req_valid[1]), .push_addr(req_addr_1), .push_burstcount(req_burstcount_1),
        .pop(q_load[1]), .empty(q_empty[1]), .full(req_full[1]),
        .head_addr(head_addr_1), .head_burstcount(head_burstcount_1)
        );

    burstcount0_gearbox #(.PAGE_SIZE(PAGE_SIZE)) gearbox_1_inst
       (
        .clk, .arst_n,
        .empty(q_empty[1]), .head_addr(head_addr_1), .head_burstcount(head_burstcount_1),
        .load(q_load[1]), .piece_accept(piece_accept[1]), .piece_valid(piece_valid[1]),
        .piece_addr(piece_addr_1), .piece_burstcount(piece_burstcount_1)
        );

    // Shared slave command bus
    burst_cmd_arbiter arbiter_inst
       (
        .clk, .arst_n,
        .piece_valid, .piece_addr_0, .piece_addr_1,
        .piece_burstcount_0, .piece_burstcount_1, .piece_accept,
        .cmd_valid, .cmd_port, .cmd_addr, .cmd_burstcount, .cmd_accept
        );

endmodule

// File: rtl/burstcount0_gearbox.sv
`timescale 1ns/1ps

module burstcount0_gearbox
  #(
    // Page size in beats, a power of two, or 0 for no page limit
    parameter int PAGE_SIZE = 16
    )
   (
    input  logic clk,
    input  logic arst_n,

    input  logic empty,
    input  burst_map_pkg::t_addr head_addr,
    input  burst_map_pkg::t_m_burstcount head_burstcount,
    output logic load,

    input  logic piece_accept,
    output logic piece_valid,
    output burst_map_pkg::t_addr piece_addr,
    output burst_map_pkg::t_s_burstcount piece_burstcount
    );

    import burst_map_pkg::*;

    // Origin-1 counts need one extra bit to hold the full burst length
    typedef logic [M_BURST_WIDTH:0] t_m_burstcount1;
    typedef logic [S_BURST_WIDTH:0] t_s_burstcount1;

    typedef enum logic
    {
        GB_IDLE,
        GB_BUSY
    } t_gb_state;

    localparam t_s_burstcount1 S_MAX = t_s_burstcount1'(2 ** S_BURST_WIDTH);

    t_gb_state state;
    t_addr cur_addr;
    t_m_burstcount1 remain;

    // Piece length limited by the slave, then by the page
    t_s_burstcount1 len_slave;
    t_s_burstcount1 len;
    logic last_piece;

    // Take a new command only when the previous one is fully sent
    assign load = !empty && (state == GB_IDLE);
    assign piece_valid = (state == GB_BUSY);
    assign piece_addr = cur_addr;
    assign piece_burstcount = t_s_burstcount'(len - t_s_burstcount1'(1));

    // The last piece carries every remaining beat
    assign last_piece = (remain == t_m_burstcount1'(len));

    always_comb
    begin
        if (remain < t_m_burstcount1'(S_MAX))
        begin
            len_slave = t_s_burstcount1'(remain);
        end
        else
        begin
            len_slave = S_MAX;
        end
    end

    generate
        if (PAGE_SIZE != 0)
        begin : g_page
            typedef logic [ADDR_WIDTH:0] t_page_room;

            // Beats left before the address reaches the next page
            t_page_room page_room;
            t_page_room page_offset;

            assign page_offset = t_page_room'(cur_addr & t_addr'(PAGE_SIZE - 1));
            assign page_room = t_page_room'(PAGE_SIZE) - page_offset;

            always_comb
            begin
                if (page_room < t_page_room'(len_slave))
                begin
                    len = t_s_burstcount1'(page_room);
                end
                else
                begin
                    len = len_slave;
                end
            end

            // First and last beat of a presented piece lie in one page
            a_no_page_cross: assert property (@(posedge clk) disable iff (!arst_n)
                piece_valid |-> ((piece_addr & ~t_addr'(PAGE_SIZE - 1))
                                 == ((piece_addr + t_addr'(piece_burstcount))
                                     & ~t_addr'(PAGE_SIZE - 1))))
                else $error("burstcount0_gearbox: piece crosses a page");
        end
        else
        begin : g_no_page
            assign len = len_slave;
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= GB_IDLE;
        end
        else if (load)
        begin
            state <= GB_BUSY;
        end
        else if (piece_accept && last_piece)
        begin
            state <= GB_IDLE;
        end
    end

    // Address and beat count walk forward one piece per accept
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            cur_addr <= head_addr;
            remain <= t_m_burstcount1'(head_burstcount) + t_m_burstcount1'(1);
        end
        else if (piece_accept)
        begin
            cur_addr <= cur_addr + t_addr'(len);
            remain <= remain - t_m_burstcount1'(len);
        end
    end

    // A piece waiting for the slave holds still until it is taken
    a_piece_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (piece_valid && !piece_accept) |=>
            (piece_valid && $stable(piece_addr) && $stable(piece_burstcount)))
        else $error("burstcount0_gearbox: piece changed without accept");

endmodule

// File: run.sh
#!/bin/sh
# Builds the burst splitter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module burst_split_tb \
    -o sim_burst_split
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_burst_split)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// File: sources.f
rtl/burst_map_pkg.sv
rtl/burst_cmd_fifo.sv
rtl/burstcount0_gearbox.sv
rtl/burst_cmd_arbiter.sv
rtl/burst_split_top.sv
tests/burst_split_checker.sv
tests/burst_split_tb.sv

// File: tests/burst_split_checker.sv
`timescale 1ns/1ps

module burst_split_checker
  #(
    parameter int PAGE_SIZE = 16
    )
   (
    input  logic clk,
    input  logic arst_n,
    input  logic [burst_map_pkg::N_PORTS-1:0] req_valid,
    input  burst_map_pkg::t_addr req_addr_0,
    input  burst_map_pkg::t_addr req_addr_1,
    input  burst_map_pkg::t_m_burstcount req_burstcount_0,
    input  burst_map_pkg::t_m_burstcount req_burstcount_1,
    input  logic [burst_map_pkg::N_PORTS-1:0] req_full,
    input  logic cmd_valid,
    input  burst_map_pkg::t_port_id cmd_port,
    input  burst_map_pkg::t_addr cmd_addr,
    input  burst_map_pkg::t_s_burstcount cmd_burstcount,
    input  logic cmd_accept,
    output int pending,
    output int errors
    );

    import burst_map_pkg::*;

    localparam int PIECE_W = ADDR_WIDTH + S_BURST_WIDTH;
    localparam int S_MAX = 1 << S_BURST_WIDTH;

    // Expected piece as address in the upper bits and origin-0 count below
    typedef logic [PIECE_W-1:0] t_piece;

    t_piece exp_q0[$];
    t_piece exp_q1[$];

    // Errors seen on the bus and errors found by the end-of-test checks
    int err_piece = 0;
    int err_end = 0;
    int pieces = 0;
    int tests_done = 0;
    int start_pieces = 0;
    int start_errors = 0;
    string cur_test = "none";
    logic alt_mode = 1'b0;
    t_port_id alt_next = '0;

    assign errors = err_piece + err_end;

    // Length of the piece that starts at addr with remain beats still to send
    function automatic int ref_piece_len(input t_addr addr, input int remain);
        int len;
        int room;
        len = (remain < S_MAX) ? remain : S_MAX;
        if (PAGE_SIZE != 0)
        begin
            room = PAGE_SIZE - (int'(addr) % PAGE_SIZE);
            if (room < len)
            begin
                len = room;
            end
        end
        return len;
    endfunction

    // Walks one request through the splitting rule and queues every piece
    task automatic expect_pieces(input int port, input t_addr addr, input t_m_burstcount bc);
        int remain;
        int len;
        t_addr a;
        t_piece p;
        remain = int'(bc) + 1;
        a = addr;
        while (remain > 0)
        begin
            len = ref_piece_len(a, remain);
            p = {a, t_s_burstcount'(len - 1)};
            if (port == 0)
            begin
                exp_q0.push_back(p);
            end
            else
            begin
                exp_q1.push_back(p);
            end
            a = a + t_addr'(len);
            remain = remain - len;
        end
    endtask

    task automatic check_piece(input t_port_id port, input t_addr addr, input t_s_burstcount bc);
        t_piece exp;
        logic found;
        found = 1'b1;
        pieces++;
        // Round-robin order only matters while both lanes stay busy
        if (alt_mode && port != alt_next)
        begin
            $display("MISMATCH %s: expected port %0d, actual port %0d", cur_test, alt_next, port);
            err_piece++;
        end
        alt_next = port + t_port_id'(1);
        if (port == t_port_id'(0) && exp_q0.size() > 0)
        begin
            exp = exp_q0.pop_front();
        end
        else if (port == t_port_id'(1) && exp_q1.size() > 0)
        begin
            exp = exp_q1.pop_front();
        end
        else
        begin
            found = 1'b0;
        end
        if (!found)
        begin
            $display("Test %s: port %0d sent a piece at %h although none was expected",
                     cur_test, port, addr);
            err_piece++;
        end
        else if (exp != {addr, bc})
        begin
            $display("MISMATCH %s port %0d: expected addr %h count %0d, actual addr %h count %0d",
                     cur_test, port, exp[PIECE_W-1:S_BURST_WIDTH], exp[S_BURST_WIDTH-1:0],
                     addr, bc);
            err_piece++;
        end
    endtask

    // Transfers are checked before new requests, which cannot reach the bus this soon
    always @(posedge clk)
    begin
        if (!arst_n)
        begin
            alt_next = '0;
        end
        else
        begin
            if (cmd_valid && cmd_accept)
            begin
                check_piece(cmd_port, cmd_addr, cmd_burstcount);
            end
            if (req_valid[0] && !req_full[0])
            begin
                expect_pieces(0, req_addr_0, req_burstcount_0);
            end
            if (req_valid[1] && !req_full[1])
            begin
                expect_pieces(1, req_addr_1, req_burstcount_1);
            end
        end
        pending = exp_q0.size() + exp_q1.size();
    end

    task automatic start_test(input string name, input logic alternate);
        cur_test = name;
        alt_mode = alternate;
        start_pieces = pieces;
        start_errors = err_piece + err_end;
    endtask

    // Compares a single status level against the value the rules call for
    task automatic check_level(input string what, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            $display("MISMATCH %s %s: expected %0b, actual %0b", cur_test, what, expected, actual);
            err_end++;
        end
    endtask

    task automatic finish_test();
        if (exp_q0.size() != 0 || exp_q1.size() != 0)
        begin
            $display("Test %s ended with %0d pieces on port 0 and %0d on port 1 never sent",
                     cur_test, exp_q0.size(), exp_q1.size());
            err_end++;
        end
        tests_done++;
        $display("Test %s done: %0d pieces, %0d errors", cur_test, pieces - start_pieces,
                 err_piece + err_end - start_errors);
    endtask

    task automatic report();
        $display("Tests %0d, pieces checked %0d, errors %0d", tests_done, pieces,
                 err_piece + err_end);
    endtask

endmodule

// File: tests/burst_split_tb.sv
`timescale 1ns/1ps

module burst_split_tb;

    import burst_map_pkg::*;

    localparam int PAGE_SIZE = 16;
    localparam int FIFO_DEPTH = 2;
    localparam int SEED = 29;
    localparam int RAND_CMDS = 12;
    // Random commands are counted at their 64-beat maximum
    localparam int TOTAL_BEATS = 1 + 64 + 10 + 4 * 16 + RAND_CMDS * 64 + 3 * 8;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_BEATS + 200;
    // Between two commands of a lane the bus is idle for at most two cycles
    localparam int QUIET_CYCLES = 8;

    logic clk;
    logic arst_n;
    logic [N_PORTS-1:0] req_valid;
    t_addr req_addr_0;
    t_addr req_addr_1;
    t_m_burstcount req_burstcount_0;
    t_m_burstcount req_burstcount_1;
    logic [N_PORTS-1:0] req_full;
    logic cmd_valid;
    t_port_id cmd_port;
    t_addr cmd_addr;
    t_s_burstcount cmd_burstcount;
    logic cmd_accept;

    int pending;
    int errors;
    int cycle_count = 0;
    // Slave back-pressure is either a fixed level or random at 3 in 4
    logic accept_random;
    logic accept_level;

    burst_split_top #(.PAGE_SIZE(PAGE_SIZE), .FIFO_DEPTH(FIFO_DEPTH)) burst_split_top_inst
       (
        .clk, .arst_n, .req_valid, .req_addr_0, .req_addr_1,
        .req_burstcount_0, .req_burstcount_1, .req_full,
        .cmd_valid, .cmd_port, .cmd_addr, .cmd_burstcount, .cmd_accept
        );

    burst_split_checker #(.PAGE_SIZE(PAGE_SIZE)) checker_inst
       (
        .clk, .arst_n, .req_valid, .req_addr_0, .req_addr_1,
        .req_burstcount_0, .req_burstcount_1, .req_full,
        .cmd_valid, .cmd_port, .cmd_addr, .cmd_burstcount, .cmd_accept,
        .pending, .errors
        );

    initial
    begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    always @(negedge clk)
    begin
        if (accept_random)
        begin
            cmd_accept = ($urandom % 4) != 0;
        end
        else
        begin
            cmd_accept = accept_level;
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d pieces still outstanding",
                     cycle_count, pending);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // One-cycle strobe, issued only once the port's queue has room
    task automatic send_cmd(input int port, input t_addr addr, input t_m_burstcount bc);
        while (req_full[port])
        begin
            @(negedge clk);
        end
        if (port == 0)
        begin
            req_addr_0 = addr;
            req_burstcount_0 = bc;
        end
        else
        begin
            req_addr_1 = addr;
            req_burstcount_1 = bc;
        end
        req_valid[port] = 1'b1;
        @(negedge clk);
        req_valid[port] = 1'b0;
    endtask

    // Both ports strobe in the same cycle so their gearboxes run in step
    task automatic send_pair(input t_addr addr_0, input t_addr addr_1, input t_m_burstcount bc);
        while (req_full != '0)
        begin
            @(negedge clk);
        end
        req_addr_0 = addr_0;
        req_addr_1 = addr_1;
        req_burstcount_0 = bc;
        req_burstcount_1 = bc;
        req_valid = '1;
        @(negedge clk);
        req_valid = '0;
    endtask

    // The DUT has drained once the slave bus stays idle for a while
    task automatic wait_drained();
        int quiet;
        quiet = 0;
        while (quiet < QUIET_CYCLES)
        begin
            @(negedge clk);
            if (cmd_valid)
            begin
                quiet = 0;
            end
            else
            begin
                quiet++;
            end
        end
    endtask

    initial
    begin
        void'($urandom(SEED));
        arst_n = 1'b0;
        req_valid = '0;
        req_addr_0 = '0;
        req_addr_1 = '0;
        req_burstcount_0 = '0;
        req_burstcount_1 = '0;
        cmd_accept = 1'b1;
        accept_random = 1'b0;
        accept_level = 1'b1;
        apply_reset();

        checker_inst.start_test("single_beat", 1'b0);
        send_cmd(0, 16'h1234, 6'd0);
        wait_drained();
        checker_inst.finish_test();

        checker_inst.start_test("slave_limit", 1'b0);
        send_cmd(0, 16'h0100, 6'd63);
        wait_drained();
        checker_inst.finish_test();

        checker_inst.start_test("page_limit", 1'b0);
        send_cmd(0, 16'h003d, 6'd9);
        wait_drained();
        checker_inst.finish_test();

        // Reset again so the first grant of this test goes to port 0
        apply_reset();
        checker_inst.start_test("round_robin", 1'b1);
        send_pair(16'h0400, 16'h0800, 6'd15);
        send_pair(16'h0410, 16'h0810, 6'd15);
        wait_drained();
        checker_inst.finish_test();

        checker_inst.start_test("random", 1'b0);
        accept_random = 1'b1;
        for (int n = 0; n < RAND_CMDS; n++)
        begin
            send_cmd(int'($urandom % 2), t_addr'($urandom), t_m_burstcount'($urandom));
        end
        wait_drained();
        accept_random = 1'b0;
        checker_inst.finish_test();

        // One command sits in the gearbox and FIFO_DEPTH more fill the queue
        checker_inst.start_test("back_pressure", 1'b0);
        accept_level = 1'b0;
        send_cmd(0, 16'h0200, 6'd7);
        send_cmd(0, 16'h0208, 6'd7);
        send_cmd(0, 16'h0210, 6'd7);
        checker_inst.check_level("req_full[0] once filled", 1'b1, req_full[0]);
        repeat (40) @(negedge clk);
        checker_inst.check_level("req_full[0] after the stall", 1'b1, req_full[0]);
        accept_level = 1'b1;
        wait_drained();
        checker_inst.finish_test();

        checker_inst.report();
        if (errors == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
